// ==== cpu_mem.f ====
verilog/cpu_mem_pkg.sv
verilog/icache.sv
verilog/uncached_port.sv
verilog/axi_bridge.sv
verilog/cpu_mem_top.sv
bench/axi_mem_model.sv
bench/cpu_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cpu_mem_tb
FILELIST  ?= cpu_mem.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and logs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/cpu_mem_tb.sv ====
`timescale 1ns/10ps

module cpu_mem_tb import cpu_mem_pkg::*; ();

    localparam int          LINE_WORDS = 4;
    localparam int          INDEX_W    = 6;
    localparam int          OFF_W      = $clog2(LINE_WORDS) + 2;
    localparam int          MEM_WORDS  = 8192;
    localparam int          N_FETCH    = 400;
    localparam int          N_DATA     = 300;
    // worst case per operation, in cycles, with stalls on both ports
    localparam longint      TIMEOUT_NS = longint'(N_FETCH + N_DATA) * 80 * 100;

    logic                aclk = 1'b0;
    logic                rst_n;
    logic                inst_req;
    logic [ADDR_W-1:0]   inst_addr;
    logic                inst_addr_ok;
    logic                inst_data_ok;
    logic [2*DATA_W-1:0] inst_rdata;
    logic                data_req;
    logic                data_wr;
    logic [STRB_W-1:0]   data_wstrb;
    logic [ADDR_W-1:0]   data_addr;
    logic [DATA_W-1:0]   data_wdata;
    logic                data_addr_ok;
    logic                data_data_ok;
    logic [DATA_W-1:0]   data_rdata;
    axi_ar_t             ar;
    axi_r_t              r;
    axi_aw_t             aw;
    axi_w_t              w;
    axi_b_t              b;
    logic                arvalid;
    logic                arready;
    logic                rvalid;
    logic                rready;
    logic                awvalid;
    logic                awready;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;

    logic [DATA_W-1:0]         ref_mem [MEM_WORDS];
    logic [2*DATA_W-1:0]       inst_exp [$];
    logic [DATA_W:0]           data_exp [$];
    logic [ADDR_W-1:0]         inst_ar_exp [$];
    logic [ADDR_W-1:0]         data_ar_exp [$];
    wr_req_t                   store_exp [$];
    wr_req_t                   store_w_exp [$];
    logic [INDEX_W-1:0]        cidx;
    logic [ADDR_W-OFF_W-INDEX_W-1:0] ctag;
    logic [ADDR_W-OFF_W-INDEX_W-1:0] res_tag [2**INDEX_W];
    logic [2**INDEX_W-1:0]     res_valid;
    logic                      hit_due;
    logic [ADDR_W-1:0]         exp_addr;
    wr_req_t                   exp_wr;
    int                        errors;
    int                        checks;
    int                        after_rst;

    cpu_mem_top dut0 (.*);

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) mem0 (.*);

    initial begin
        forever #50 aclk = ~aclk;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic fetch(input logic [ADDR_W-1:0] a);
        inst_req  = 1'b1;
        inst_addr = a;
        @(negedge aclk);
        while (!inst_addr_ok) @(negedge aclk);
        @(posedge aclk);
        #1;
        inst_req = 1'b0;
    endtask

    task automatic access(input logic wr, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
        data_req   = 1'b1;
        data_wr    = wr;
        data_addr  = a;
        data_wdata = d;
        data_wstrb = s;
        @(negedge aclk);
        while (!data_addr_ok) @(negedge aclk);
        @(posedge aclk);
        #1;
        data_req = 1'b0;
    endtask

    // reference model, everything sampled mid-cycle
    always @(negedge aclk) begin
        if (!rst_n || after_rst < 2) begin
            checks++;
            assert (!arvalid && !awvalid && !wvalid && !rready && !bready
                    && !inst_data_ok && !data_data_ok)
                else report_error("bus or data_ok active during reset");
        end
        if (rst_n) begin
            after_rst++;
            // a hit answers one cycle after it was taken
            if (hit_due) begin
                checks++;
                assert (inst_data_ok) else report_error("hit not answered in the next cycle");
            end
            hit_due = 1'b0;
            if (inst_req && inst_addr_ok) begin
                inst_exp.push_back({ref_mem[inst_addr[14:2] + 13'd1], ref_mem[inst_addr[14:2]]});
                cidx = inst_addr[OFF_W +: INDEX_W];
                ctag = inst_addr[ADDR_W-1:OFF_W+INDEX_W];
                if (!res_valid[cidx] || res_tag[cidx] != ctag) begin
                    inst_ar_exp.push_back({inst_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}});
                    res_valid[cidx] = 1'b1;
                    res_tag[cidx]   = ctag;
                end else begin
                    hit_due = 1'b1;
                end
            end
            if (inst_data_ok) begin
                assert (inst_exp.size() > 0) else report_error("inst_data_ok with no fetch");
                if (inst_exp.size() > 0) begin
                    compare_value("inst_rdata", inst_rdata, inst_exp.pop_front());
                end
            end
            if (data_req && data_addr_ok) begin
                if (data_wr) begin
                    store_exp.push_back('{addr: data_addr, data: data_wdata, strb: data_wstrb});
                    store_w_exp.push_back('{addr: data_addr, data: data_wdata, strb: data_wstrb});
                    for (int k = 0; k < STRB_W; k++) begin
                        if (data_wstrb[k]) begin
                            ref_mem[data_addr[14:2]][8*k +: 8] = data_wdata[8*k +: 8];
                        end
                    end
                    data_exp.push_back({1'b0, 32'h0});
                end else begin
                    data_ar_exp.push_back(data_addr);
                    data_exp.push_back({1'b1, ref_mem[data_addr[14:2]]});
                end
            end
            if (data_data_ok) begin
                assert (data_exp.size() > 0) else report_error("data_data_ok with no access");
                if (data_exp.size() > 0 && data_exp[0][DATA_W]) begin
                    compare_value("data_rdata", data_rdata, data_exp[0][DATA_W-1:0]);
                end
                if (data_exp.size() > 0) begin
                    void'(data_exp.pop_front());
                end
            end
            if (arvalid && arready) begin
                compare_value("ar.burst", ar.burst, BURST_INCR);
                compare_value("ar.size", ar.size, SIZE_WORD);
                if (ar.id == INST_ID) begin
                    assert (inst_ar_exp.size() > 0) else report_error("refill AR without a miss");
                    exp_addr = (inst_ar_exp.size() > 0) ? inst_ar_exp.pop_front() : '0;
                    compare_value("ar.addr", ar.addr, exp_addr);
                    compare_value("ar.len", ar.len, LINE_WORDS - 1);
                end else begin
                    compare_value("ar.id", ar.id, DATA_ID);
                    assert (data_ar_exp.size() > 0) else report_error("data AR without a load");
                    exp_addr = (data_ar_exp.size() > 0) ? data_ar_exp.pop_front() : '0;
                    compare_value("ar.addr", ar.addr, exp_addr);
                    compare_value("ar.len", ar.len, 0);
                end
            end
            if (awvalid && awready) begin
                assert (store_exp.size() > 0) else report_error("AW without a store");
                exp_wr = (store_exp.size() > 0) ? store_exp.pop_front() : '0;
                compare_value("aw.id", aw.id, DATA_ID);
                compare_value("aw.addr", aw.addr, exp_wr.addr);
                compare_value("aw.len", aw.len, 0);
                compare_value("aw.size", aw.size, SIZE_WORD);
                compare_value("aw.burst", aw.burst, BURST_INCR);
            end
            if (wvalid && wready) begin
                assert (store_w_exp.size() > 0) else report_error("W without a store");
                exp_wr = (store_w_exp.size() > 0) ? store_w_exp.pop_front() : '0;
                compare_value("w.id", w.id, DATA_ID);
                compare_value("w.data", w.data, exp_wr.data);
                compare_value("w.strb", w.strb, exp_wr.strb);
                compare_value("w.last", w.last, 1'b1);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        errors++;
        $display("Error: watchdog expired before all traffic completed");
        $display("checks %0d, errors %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        inst_req   = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_wstrb = '0;
        data_addr  = '0;
        data_wdata = '0;
        errors     = 0;
        checks     = 0;
        after_rst  = 0;
        res_valid  = '0;
        hit_due    = 1'b0;
        void'($urandom(32'h1ec70a48));
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]  = $urandom;
            mem0.mem[i] = ref_mem[i];
        end
        repeat (8) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        fork
            begin
                for (int n = 0; n < N_FETCH; n++) begin
                    repeat ($urandom % 3) begin
                        @(posedge aclk);
                        #1;
                    end
                    // four tags per index in 4 KB
                    fetch(($urandom % 512) * 8);
                end
            end
            begin
                for (int n = 0; n < N_DATA; n++) begin
                    repeat ($urandom % 4) begin
                        @(posedge aclk);
                        #1;
                    end
                    access($urandom % 2, 32'h4000 + ($urandom % 256) * 4, $urandom,
                           4'($urandom % 15 + 1));
                end
            end
        join
        while (inst_exp.size() > 0 || data_exp.size() > 0) @(negedge aclk);
        repeat (10) @(negedge aclk);
        assert (inst_ar_exp.size() == 0 && data_ar_exp.size() == 0)
            else report_error("expected AR never issued");
        assert (store_exp.size() == 0 && store_w_exp.size() == 0)
            else report_error("expected AW or W never issued");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/10ps

module axi_mem_model import cpu_mem_pkg::*; #(
    parameter int MEM_WORDS = 8192
) (
    input  logic    aclk,
    input  logic    rst_n,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    axi_ar_t           rd_cmd;
    logic [7:0]        beat;
    logic              rd_busy;
    axi_aw_t           aw_cmd;
    axi_w_t            w_beat;
    logic              aw_got;
    logic              w_got;
    logic              in_rst;
    logic              hold_r;
    logic              hold_b;
    logic [IDX_W-1:0]  idx;

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        b       = '0;
    end

    always @(posedge aclk) begin
        in_rst = !rst_n;
        hold_r = rvalid && !rready;
        hold_b = bvalid && !bready;
        if (in_rst) begin
            rd_busy = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            beat    = '0;
        end else begin
            if (arvalid && arready) begin
                rd_cmd  = ar;
                rd_busy = 1'b1;
                beat    = '0;
            end
            if (rvalid && rready) begin
                if (r.last) begin
                    rd_busy = 1'b0;
                end else begin
                    beat = beat + 8'd1;
                end
            end
            if (awvalid && awready) begin
                aw_cmd = aw;
                aw_got = 1'b1;
            end
            if (wvalid && wready) begin
                w_beat = w;
                w_got  = 1'b1;
            end
            if (bvalid && bready) begin
                idx = aw_cmd.addr[IDX_W+1:2];
                for (int k = 0; k < STRB_W; k++) begin
                    if (w_beat.strb[k]) begin
                        mem[idx][8*k +: 8] = w_beat.data[8*k +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
        end
        #1;
        // random stalls on every channel
        arready = !in_rst && !rd_busy && ($urandom % 4 != 0);
        awready = !in_rst && !aw_got && ($urandom % 3 != 0);
        wready  = !in_rst && !w_got && ($urandom % 3 != 0);
        if (!hold_r) begin
            rvalid = !in_rst && rd_busy && ($urandom % 3 != 0);
            idx    = rd_cmd.addr[IDX_W+1:2] + IDX_W'(beat);
            r      = '{id: rd_cmd.id, data: mem[idx], resp: 2'b00, last: (beat == rd_cmd.len)};
        end
        if (!hold_b) begin
            bvalid = !in_rst && aw_got && w_got && ($urandom % 2 != 0);
            b      = '{id: aw_cmd.id, resp: 2'b00};
        end
    end

endmodule

// ==== verilog/cpu_mem_top.sv ====
`timescale 1ns/10ps

module cpu_mem_top import cpu_mem_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int INDEX_W    = 6
) (
    input  logic                aclk,
    input  logic                rst_n,

    input  logic                inst_req,
    input  logic [ADDR_W-1:0]   inst_addr,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,
    output logic [2*DATA_W-1:0] inst_rdata,

    input  logic                data_req,
    input  logic                data_wr,
    input  logic [STRB_W-1:0]   data_wstrb,
    input  logic [ADDR_W-1:0]   data_addr,
    input  logic [DATA_W-1:0]   data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output logic [DATA_W-1:0]   data_rdata,

    output axi_ar_t             ar,
    output logic                arvalid,
    input  logic                arready,
    input  axi_r_t              r,
    input  logic                rvalid,
    output logic                rready,
    output axi_aw_t             aw,
    output logic                awvalid,
    input  logic                awready,
    output axi_w_t              w,
    output logic                wvalid,
    input  logic                wready,
    input  axi_b_t              b,
    input  logic                bvalid,
    output logic                bready
);

    logic              i_rd_req;
    rd_req_t           i_rd;
    logic              i_rd_rdy;
    logic              i_ret_valid;
    logic              i_ret_last;
    logic [DATA_W-1:0] i_ret_data;

    logic              d_rd_req;
    rd_req_t           d_rd;
    logic              d_rd_rdy;
    logic              d_ret_valid;
    logic              d_ret_last;
    logic [DATA_W-1:0] d_ret_data;
    logic              d_wr_req;
    wr_req_t           d_wr;
    logic              d_wr_rdy;

    icache #(
        .LINE_WORDS(LINE_WORDS),
        .INDEX_W(INDEX_W)
    ) icache_0 (
        .aclk(aclk),
        .rst_n(rst_n),
        .inst_req(inst_req),
        .inst_addr(inst_addr),
        .inst_addr_ok(inst_addr_ok),
        .inst_data_ok(inst_data_ok),
        .inst_rdata(inst_rdata),
        .rd_req(i_rd_req),
        .rd(i_rd),
        .rd_rdy(i_rd_rdy),
        .ret_valid(i_ret_valid),
        .ret_last(i_ret_last),
        .ret_data(i_ret_data)
    );

    uncached_port uncached_port_0 (
        .aclk(aclk),
        .rst_n(rst_n),
        .data_req(data_req),
        .data_wr(data_wr),
        .data_wstrb(data_wstrb),
        .data_addr(data_addr),
        .data_wdata(data_wdata),
        .data_addr_ok(data_addr_ok),
        .data_data_ok(data_data_ok),
        .data_rdata(data_rdata),
        .rd_req(d_rd_req),
        .rd(d_rd),
        .rd_rdy(d_rd_rdy),
        .ret_valid(d_ret_valid),
        .ret_last(d_ret_last),
        .ret_data(d_ret_data),
        .wr_req(d_wr_req),
        .wr(d_wr),
        .wr_rdy(d_wr_rdy)
    );

    axi_bridge axi_bridge_0 (
        .aclk(aclk),
        .rst_n(rst_n),
        .i_rd_req(i_rd_req),
        .i_rd(i_rd),
        .i_rd_rdy(i_rd_rdy),
        .i_ret_valid(i_ret_valid),
        .i_ret_last(i_ret_last),
        .i_ret_data(i_ret_data),
        .d_rd_req(d_rd_req),
        .d_rd(d_rd),
        .d_rd_rdy(d_rd_rdy),
        .d_ret_valid(d_ret_valid),
        .d_ret_last(d_ret_last),
        .d_ret_data(d_ret_data),
        .d_wr_req(d_wr_req),
        .d_wr(d_wr),
        .d_wr_rdy(d_wr_rdy),
        .ar(ar),
        .arvalid(arvalid),
        .arready(arready),
        .r(r),
        .rvalid(rvalid),
        .rready(rready),
        .aw(aw),
        .awvalid(awvalid),
        .awready(awready),
        .w(w),
        .wvalid(wvalid),
        .wready(wready),
        .b(b),
        .bvalid(bvalid),
        .bready(bready)
    );

endmodule

// ==== verilog/axi_bridge.sv ====
`timescale 1ns/10ps

module axi_bridge import cpu_mem_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,

    input  logic              i_rd_req,
    input  rd_req_t           i_rd,
    output logic              i_rd_rdy,
    output logic              i_ret_valid,
    output logic              i_ret_last,
    output logic [DATA_W-1:0] i_ret_data,

    input  logic              d_rd_req,
    input  rd_req_t           d_rd,
    output logic              d_rd_rdy,
    output logic              d_ret_valid,
    output logic              d_ret_last,
    output logic [DATA_W-1:0] d_ret_data,
    input  logic              d_wr_req,
    input  wr_req_t           d_wr,
    output logic              d_wr_rdy,

    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready,
    output axi_aw_t           aw,
    output logic              awvalid,
    input  logic              awready,
    output axi_w_t            w,
    output logic              wvalid,
    input  logic              wready,
    input  axi_b_t            b,
    input  logic              bvalid,
    output logic              bready
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_RESP
    } wr_state_t;

    rd_state_t rd_state;
    wr_state_t wr_state;
    rd_req_t   sel_rd;
    logic      aw_pend;
    logic      w_pend;

    // data reads take priority over refills
    assign sel_rd = d_rd_req ? d_rd : i_rd;

    assign d_rd_rdy = (rd_state == R_ADDR) && arready && (ar.id == DATA_ID);
    assign i_rd_rdy = (rd_state == R_ADDR) && arready && (ar.id == INST_ID);

    assign rready      = (rd_state == R_DATA);
    assign d_ret_valid = rvalid && rready && (r.id == DATA_ID);
    assign i_ret_valid = rvalid && rready && (r.id == INST_ID);
    assign d_ret_last  = r.last;
    assign i_ret_last  = r.last;
    assign d_ret_data  = r.data;
    assign i_ret_data  = r.data;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rd_state <= R_IDLE;
            arvalid  <= 1'b0;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (d_rd_req || i_rd_req) begin
                        arvalid  <= 1'b1;
                        rd_state <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (arready) begin
                        arvalid  <= 1'b0;
                        rd_state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (rvalid && r.last) begin
                        rd_state <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    // payload loads only while idle, so it holds through the handshake
    always_ff @(posedge aclk) begin
        if (rd_state == R_IDLE) begin
            ar <= '{id:    d_rd_req ? DATA_ID : INST_ID,
                    addr:  sel_rd.addr,
                    len:   sel_rd.len,
                    size:  SIZE_WORD,
                    burst: BURST_INCR};
        end
    end

    // aw and w are accepted independently
    assign aw_pend = awvalid && !awready;
    assign w_pend  = wvalid && !wready;

    assign bready   = (wr_state == W_RESP);
    assign d_wr_rdy = bready && bvalid;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_state <= W_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (d_wr_req) begin
                        awvalid  <= 1'b1;
                        wvalid   <= 1'b1;
                        wr_state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    awvalid <= aw_pend;
                    wvalid  <= w_pend;
                    if (!aw_pend && !w_pend) begin
                        wr_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_state == W_IDLE) begin
            aw <= '{id: DATA_ID, addr: d_wr.addr, len: 8'd0, size: SIZE_WORD, burst: BURST_INCR};
            w  <= '{id: DATA_ID, data: d_wr.data, strb: d_wr.strb, last: 1'b1};
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n)
        rvalid |-> (rd_state == R_DATA) && (r.id == ar.id));

    assert property (@(posedge aclk) disable iff (!rst_n)
        bvalid |-> (wr_state == W_RESP) && (b.id == aw.id));

    assert property (@(posedge aclk) disable iff (!rst_n)
        (arvalid && !arready) |=> arvalid && $stable(ar));

    assert property (@(posedge aclk) disable iff (!rst_n)
        (aw_pend || w_pend) |=> $stable(aw) && $stable(w));

endmodule

// ==== verilog/uncached_port.sv ====
`timescale 1ns/10ps

module uncached_port import cpu_mem_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,

    input  logic              data_req,
    input  logic              data_wr,
    input  logic [STRB_W-1:0] data_wstrb,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,
    output logic [DATA_W-1:0] data_rdata,

    output logic              rd_req,
    output rd_req_t           rd,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [DATA_W-1:0] ret_data,

    output logic              wr_req,
    output wr_req_t           wr,
    input  logic              wr_rdy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_RET,
        S_WR
    } state_t;

    state_t  state;
    wr_req_t acc;

    // one access in flight
    assign data_addr_ok = (state == S_IDLE);

    assign rd_req = (state == S_RD);
    assign rd     = '{addr: acc.addr, len: 8'd0};
    assign wr_req = (state == S_WR);
    assign wr     = acc;

    // stores finish on the write response
    assign data_data_ok = ((state == S_RET) && ret_valid) || ((state == S_WR) && wr_rdy);
    assign data_rdata   = ret_data;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (data_req) begin
                        state <= data_wr ? S_WR : S_RD;
                    end
                end
                S_RD: begin
                    if (rd_rdy) begin
                        state <= S_RET;
                    end
                end
                S_RET: begin
                    if (ret_valid && ret_last) begin
                        state <= S_IDLE;
                    end
                end
                S_WR: begin
                    if (wr_rdy) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (data_req && data_addr_ok) begin
            acc <= '{addr: data_addr, data: data_wdata, strb: data_wstrb};
        end
    end

    // the bridge must return single beats for this port
    assert property (@(posedge aclk) disable iff (!rst_n)
        ((state == S_RET) && ret_valid) |-> ret_last);

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/10ps

module icache import cpu_mem_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int INDEX_W    = 6
) (
    input  logic                aclk,
    input  logic                rst_n,

    input  logic                inst_req,
    input  logic [ADDR_W-1:0]   inst_addr,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,
    output logic [2*DATA_W-1:0] inst_rdata,

    output logic                rd_req,
    output rd_req_t             rd,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [DATA_W-1:0]   ret_data
);

    localparam int WORD_W   = $clog2(LINE_WORDS);
    localparam int OFFSET_W = WORD_W + 2;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS     = 2 ** INDEX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOK,
        S_MISS,
        S_REFILL
    } state_t;

    state_t                            state;
    logic [ADDR_W-1:0]                 req_addr;
    logic [WORD_W-1:0]                 beat_cnt;
    logic [SETS-1:0]                   valid_bits;
    logic [TAG_W-1:0]                  tag_mem [SETS];
    logic [LINE_WORDS-1:0][DATA_W-1:0] data_mem [SETS];

    logic [TAG_W-1:0]                  req_tag;
    logic [INDEX_W-1:0]                req_index;
    logic [WORD_W-1:0]                 req_word;
    logic [LINE_WORDS-1:0][DATA_W-1:0] line;
    logic                              hit;
    logic                              accept;

    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_addr[2 +: WORD_W];
    assign line      = data_mem[req_index];
    assign hit       = valid_bits[req_index] && (tag_mem[req_index] == req_tag);

    // a hit cycle also takes the next fetch
    assign inst_data_ok = (state == S_LOOK) && hit;
    assign inst_addr_ok = (state == S_IDLE) || inst_data_ok;
    assign accept       = inst_req && inst_addr_ok;

    // word pair, even word in the low half
    assign inst_rdata = {line[req_word | WORD_W'(1)], line[req_word]};

    assign rd_req = (state == S_MISS);
    assign rd     = '{addr: {req_tag, req_index, {OFFSET_W{1'b0}}}, len: 8'(LINE_WORDS - 1)};

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            valid_bits <= '0;
            beat_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE, S_LOOK: begin
                    if (accept) begin
                        state <= S_LOOK;
                    end else if (state == S_LOOK && !hit) begin
                        state <= S_MISS;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_MISS: begin
                    if (rd_rdy) begin
                        state    <= S_REFILL;
                        beat_cnt <= '0;
                    end
                end
                S_REFILL: begin
                    if (ret_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // look up again once the line is in
                        if (ret_last) begin
                            valid_bits[req_index] <= 1'b1;
                            state                 <= S_LOOK;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_addr <= inst_addr;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_REFILL && ret_valid) begin
            data_mem[req_index][beat_cnt] <= ret_data;
            if (ret_last) begin
                tag_mem[req_index] <= req_tag;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n)
        accept |-> (inst_addr[2:0] == 3'b000));

    // refill burst is exactly one line long
    assert property (@(posedge aclk) disable iff (!rst_n)
        (state == S_REFILL && ret_valid) |->
            (ret_last == (beat_cnt == WORD_W'(LINE_WORDS - 1))));

endmodule

// ==== verilog/cpu_mem_pkg.sv ====
package cpu_mem_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int AXI_ID_W = 4;

    // refills and data accesses are told apart by id
    localparam logic [AXI_ID_W-1:0] INST_ID = 4'd0;
    localparam logic [AXI_ID_W-1:0] DATA_ID = 4'd1;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_WORD  = 3'b010;

    // len is beats minus one, as on AXI
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [ADDR_W-1:0]   addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [DATA_W-1:0]   data;
        logic [1:0]          resp;
        logic                last;
    } axi_r_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [ADDR_W-1:0]   addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage
